// ==== rename_macros.svh ====
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// ***************************************************************************
// Table and tag sizes
// ***************************************************************************
`define NUM_LOGICAL 32           // Architectural registers.
`define NUM_PHYS    160          // Physical tags in the machine.
`define TAG_W       8            // Physical tag width.

// ***************************************************************************
// Checkpoints and free list
// ***************************************************************************
`define NUM_PAGES   8            // One page per unresolved branch.
`define PAGE_W      3
`define FREE_DEPTH  128          // Tags 32 to 159 start here.

// Reserved tag codes
`define TAG_NO_SRC  8'hFE
`define TAG_NO_DST  8'hFF

`endif

// ==== rename_pkg.sv ====
`include "rename_macros.svh"

package rename_pkg;

    typedef logic [`TAG_W-1:0]                  phys_tag_t;
    typedef logic [$clog2(`NUM_LOGICAL)-1:0]    log_reg_t;
    typedef logic [`PAGE_W-1:0]                 page_t;
    typedef logic [$clog2(`FREE_DEPTH)-1:0]     free_ptr_t;

    // RV32I major opcodes.
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        src1_only,
        no_src,
        two_src,
        no_dst_two_src
    } op_class_e;

    typedef enum logic [1:0] {
        st_run,
        st_restore
    } ctrl_state_e;

endpackage

// ==== map_table.sv ====
`include "rename_macros.svh"

module map_table import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      accept,
    input  logic      use_src1,
    input  logic      use_src2,
    input  log_reg_t  rd_addr1,
    input  log_reg_t  rd_addr2,
    input  log_reg_t  ren_addr,
    input  logic      ren_we,
    input  phys_tag_t ren_tag,
    input  logic      restore_we,
    input  log_reg_t  restore_row,
    input  phys_tag_t restore_tag,
    output phys_tag_t rd_tag1,
    output phys_tag_t rd_tag2,
    output phys_tag_t old_tag,
    output phys_tag_t dst_tag,
    output phys_tag_t snapshot [`NUM_LOGICAL]
);

    phys_tag_t table_q [`NUM_LOGICAL];

    // ***********************************************************************
    // Mapping storage
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_LOGICAL; i++) begin
                table_q[i] <= phys_tag_t'(i);       // Identity mapping.
            end
        end else if (ren_we) begin
            table_q[ren_addr] <= ren_tag;
        end else if (restore_we) begin
            table_q[restore_row] <= restore_tag;    // One row per cycle.
        end
    end

    assign snapshot = table_q;

    // ***********************************************************************
    // Registered rename results
    // ***********************************************************************
    // Reads see the table before this edge, so a source that names the
    // destination of the same instruction gets the older mapping.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_tag1 <= `TAG_NO_SRC;
            rd_tag2 <= `TAG_NO_SRC;
            old_tag <= `TAG_NO_DST;
            dst_tag <= `TAG_NO_DST;
        end else if (accept) begin
            rd_tag1 <= use_src1 ? table_q[rd_addr1] : `TAG_NO_SRC;
            rd_tag2 <= use_src2 ? table_q[rd_addr2] : `TAG_NO_SRC;
            old_tag <= ren_we ? table_q[ren_addr] : `TAG_NO_DST;   // Displaced tag.
            dst_tag <= ren_we ? ren_tag : `TAG_NO_DST;
        end
    end

    // A restore only runs while renaming is stalled.
    assert property (@(posedge clk) disable iff (reset)
        !(ren_we && restore_we))
        else $error("map_table: rename and restore write in the same cycle");

endmodule

// ==== checkpoint_store.sv ====
`include "rename_macros.svh"

module checkpoint_store import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      save_en,
    input  page_t     save_page,
    input  phys_tag_t snapshot [`NUM_LOGICAL],
    input  free_ptr_t save_head,
    input  page_t     read_page,
    input  log_reg_t  read_row,
    output phys_tag_t read_tag,
    output free_ptr_t read_head
);

    phys_tag_t page_q [`NUM_PAGES][`NUM_LOGICAL];
    free_ptr_t head_q [`NUM_PAGES];

    // ***********************************************************************
    // Snapshot pages
    // ***********************************************************************
    // The whole table lands in the page on a single edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < `NUM_PAGES; p++) begin
                head_q[p] <= '0;
                for (int r = 0; r < `NUM_LOGICAL; r++) begin
                    page_q[p][r] <= '0;
                end
            end
        end else if (save_en) begin
            head_q[save_page] <= save_head;         // Head before any alloc this cycle.
            for (int r = 0; r < `NUM_LOGICAL; r++) begin
                page_q[save_page][r] <= snapshot[r];
            end
        end
    end

    // Read back
    assign read_tag  = page_q[read_page][read_row];
    assign read_head = head_q[read_page];

endmodule

// ==== free_list.sv ====
`include "rename_macros.svh"

module free_list import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      alloc,
    input  logic      release_en,
    input  phys_tag_t release_tag,
    input  logic      rewind,
    input  free_ptr_t rewind_head,
    output phys_tag_t head_tag,
    output free_ptr_t head_ptr,
    output logic      empty
);

    localparam int CNT_W = $clog2(`FREE_DEPTH) + 1;

    phys_tag_t        ring_q [`FREE_DEPTH];
    free_ptr_t        head_q;
    free_ptr_t        tail_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    free_ptr_t        rewound;

    // Tags handed out since the checkpoint come back with the old head.
    assign rewound = head_q - rewind_head;

    always_comb begin
        count_d = count_q;
        if (rewind) begin
            count_d = count_d + {1'b0, rewound};
        end
        if (release_en) begin
            count_d = count_d + 1'b1;
        end
        if (alloc) begin
            count_d = count_d - 1'b1;
        end
    end

    // ***********************************************************************
    // Ring and pointers
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                ring_q[i] <= phys_tag_t'(`NUM_LOGICAL + i);
            end
            head_q  <= '0;
            tail_q  <= '0;                          // Full ring, tail meets head.
            count_q <= CNT_W'(`FREE_DEPTH);
        end else begin
            if (release_en) begin
                ring_q[tail_q] <= release_tag;
                tail_q         <= tail_q + 1'b1;
            end
            if (rewind) begin
                head_q <= rewind_head;
            end else if (alloc) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_d;
        end
    end

    assign head_tag = ring_q[head_q];
    assign head_ptr = head_q;
    assign empty    = (count_q == '0);

    assert property (@(posedge clk) disable iff (reset) alloc |-> !empty)
        else $error("free_list: allocate while empty");

    // Commit only returns tags that exist.
    assert property (@(posedge clk) disable iff (reset)
        release_en |-> (release_tag < `NUM_PHYS))
        else $error("free_list: released tag out of range");

endmodule

// ==== restore_counter.sv ====
`include "rename_macros.svh"

module restore_counter import rename_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output log_reg_t row,
    output logic     last,
    output logic     busy
);

    always_ff @(posedge clk) begin
        if (reset) begin
            row  <= '0;
            busy <= 1'b0;
        end else if (start) begin
            row  <= '0;
            busy <= 1'b1;
        end else if (busy) begin
            row  <= row + 1'b1;                     // Wraps to 0 after the last row.
            busy <= !last;
        end
    end

    assign last = busy && (row == log_reg_t'(`NUM_LOGICAL - 1));

    assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("restore_counter: start during a restore walk");

endmodule

// ==== rename_ctrl.sv ====
`include "rename_macros.svh"

module rename_ctrl import rename_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  opcode_e opcode,
    input  logic    save,
    input  logic    restore,
    input  logic    free_empty,
    input  logic    last,
    output logic    in_ready,
    output logic    accept,
    output logic    ren_we,
    output logic    alloc,
    output logic    save_en,
    output logic    restore_start,
    output logic    restore_we,
    output logic    rewind,
    output logic    use_src1,
    output logic    use_src2,
    output logic    out_valid
);

    ctrl_state_e state_q;
    op_class_e   op_class;
    logic        need_dst;
    logic        ready_base;

    // ***********************************************************************
    // Opcode classes
    // ***********************************************************************
    always_comb begin
        case (opcode)
            op_jalr, op_load, op_imm: op_class = src1_only;
            op_lui, op_auipc, op_jal: op_class = no_src;
            op_branch, op_store:      op_class = no_dst_two_src;
            default:                  op_class = two_src;
        endcase
    end

    assign need_dst = (op_class != no_dst_two_src);
    assign use_src1 = (op_class != no_src);
    assign use_src2 = (op_class == two_src) || (op_class == no_dst_two_src);

    // Handshake
    assign ready_base    = (state_q == st_run) && !(free_empty && need_dst);
    assign in_ready      = ready_base && !restore;  // Restore wins the cycle.
    assign accept        = in_valid && in_ready;
    assign ren_we        = accept && need_dst;
    assign alloc         = ren_we;
    assign save_en       = save && (state_q == st_run);
    assign restore_start = restore && ready_base;
    assign rewind        = restore_start;           // Head goes back on the accept edge.
    assign restore_we    = (state_q == st_restore);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= st_run;
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
            case (state_q)
                st_run: begin
                    if (restore_start) begin
                        state_q <= st_restore;
                    end
                end
                st_restore: begin
                    if (last) begin
                        state_q <= st_run;
                    end
                end
                default: begin
                    state_q <= st_run;
                end
            endcase
        end
    end

    // The row walk and the copy into the table stay in step.
    assert property (@(posedge clk) disable iff (reset)
        (state_q == st_run) |-> !last)
        else $error("rename_ctrl: restore activity outside st_restore");

endmodule

// ==== rename_top.sv ====
`include "rename_macros.svh"

module rename_top import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  opcode_e   opcode,
    input  log_reg_t  src1,
    input  log_reg_t  src2,
    input  log_reg_t  dst,
    input  logic      save,
    input  page_t     save_page,
    input  logic      restore,
    input  page_t     restore_page,
    input  logic      commit_valid,
    input  phys_tag_t commit_tag,
    output logic      in_ready,
    output logic      out_valid,
    output phys_tag_t src1_tag,
    output phys_tag_t src2_tag,
    output phys_tag_t dst_tag,
    output phys_tag_t old_tag
);

    logic      accept;
    logic      ren_we;
    logic      alloc;
    logic      save_en;
    logic      restore_start;
    logic      restore_we;
    logic      rewind;
    logic      use_src1;
    logic      use_src2;
    logic      free_empty;
    logic      last;
    log_reg_t  row;
    phys_tag_t head_tag;
    free_ptr_t head_ptr;
    phys_tag_t read_tag;
    free_ptr_t read_head;
    phys_tag_t snapshot [`NUM_LOGICAL];

    rename_ctrl ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .opcode        (opcode),
        .save          (save),
        .restore       (restore),
        .free_empty    (free_empty),
        .last          (last),
        .in_ready      (in_ready),
        .accept        (accept),
        .ren_we        (ren_we),
        .alloc         (alloc),
        .save_en       (save_en),
        .restore_start (restore_start),
        .restore_we    (restore_we),
        .rewind        (rewind),
        .use_src1      (use_src1),
        .use_src2      (use_src2),
        .out_valid     (out_valid)
    );

    restore_counter counter_i (
        .clk   (clk),
        .reset (reset),
        .start (restore_start),
        .row   (row),
        .last  (last),
        .busy  ()
    );

    map_table map_i (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .use_src1    (use_src1),
        .use_src2    (use_src2),
        .rd_addr1    (src1),
        .rd_addr2    (src2),
        .ren_addr    (dst),
        .ren_we      (ren_we),
        .ren_tag     (head_tag),
        .restore_we  (restore_we),
        .restore_row (row),
        .restore_tag (read_tag),
        .rd_tag1     (src1_tag),
        .rd_tag2     (src2_tag),
        .old_tag     (old_tag),
        .dst_tag     (dst_tag),
        .snapshot    (snapshot)
    );

    // restore_page is held by the producer until in_ready comes back.
    checkpoint_store ckpt_i (
        .clk       (clk),
        .reset     (reset),
        .save_en   (save_en),
        .save_page (save_page),
        .snapshot  (snapshot),
        .save_head (head_ptr),
        .read_page (restore_page),
        .read_row  (row),
        .read_tag  (read_tag),
        .read_head (read_head)
    );

    free_list free_i (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .release_en  (commit_valid),
        .release_tag (commit_tag),
        .rewind      (rewind),
        .rewind_head (read_head),
        .head_tag    (head_tag),
        .head_ptr    (head_ptr),
        .empty       (free_empty)
    );

endmodule

// ==== tb_checker.sv ====
`include "rename_macros.svh"

module tb_checker import rename_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      in_ready,
    input logic      out_valid,
    input phys_tag_t src1_tag,
    input phys_tag_t src2_tag,
    input phys_tag_t dst_tag,
    input phys_tag_t old_tag
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;                 // Same clock as tb_rename.

    logic [31:0] exp_q [$];                         // {src1, src2, dst, old}.
    time         stamp_q [$];                       // Transfer edge of each entry.
    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          test_checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    task automatic flag_error(input string msg);
        $display("Checker error at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic compare_value(input string what, input int got, input int exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // ***********************************************************************
    // Calls from the testbench top
    // ***********************************************************************
    task automatic expect_out(input phys_tag_t s1, input phys_tag_t s2,
                              input phys_tag_t d, input phys_tag_t o);
        exp_q.push_back({s1, s2, d, o});
        stamp_q.push_back($time);
    endtask

    task automatic check_ready(input logic exp, input string what);
        compare_value(what, int'(in_ready), int'(exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        compare_value(what, got, exp);
    endtask

    task automatic check_idle();
        compare_value("out_valid after reset", int'(out_valid), 0);
        compare_value("in_ready after reset", int'(in_ready), 1);
        compare_value("src1_tag after reset", src1_tag, `TAG_NO_SRC);
        compare_value("src2_tag after reset", src2_tag, `TAG_NO_SRC);
        compare_value("dst_tag after reset", dst_tag, `TAG_NO_DST);
        compare_value("old_tag after reset", old_tag, `TAG_NO_DST);
    endtask

    task automatic end_test(input int id, input string name);
        if (exp_q.size() != 0) begin
            flag_error($sformatf("%0d renamed results never appeared", exp_q.size()));
            exp_q.delete();
            stamp_q.delete();
        end
        $display("Test %0d (%s): %0d checks, %0d errors", id, name, test_checks,
                 test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic report_counts();
        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d", tests_run,
                 tests_failed, checks, errors);
    endtask

    // ***********************************************************************
    // Output watcher
    // ***********************************************************************
    always @(posedge clk) begin
        logic [31:0] e;
        time         t;
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                flag_error("out_valid rose with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                t = stamp_q.pop_front();
                compare_value("cycles from transfer to out_valid",
                              int'(($time - t) / CLK_PERIOD), 1);
                compare_value("src1_tag", src1_tag, e[31:24]);
                compare_value("src2_tag", src2_tag, e[23:16]);
                compare_value("dst_tag", dst_tag, e[15:8]);
                compare_value("old_tag", old_tag, e[7:0]);
            end
        end
    end

endmodule

// ==== tb_rename.sv ====
`include "rename_macros.svh"

module tb_rename import rename_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [3:0] test;
        opcode_e    op;
        log_reg_t   s1;
        log_reg_t   s2;
        log_reg_t   d;
        logic       sv;
        page_t      sp;
        logic       rs;
        page_t      rp;
        logic       cm;
        logic [7:0] rep;                            // Zero repeats until the list is empty.
    } row_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid;
    opcode_e   opcode;
    log_reg_t  src1;
    log_reg_t  src2;
    log_reg_t  dst;
    logic      save;
    page_t     save_page;
    logic      restore;
    page_t     restore_page;
    logic      commit_valid;
    phys_tag_t commit_tag;
    logic      in_ready;
    logic      out_valid;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t dst_tag;
    phys_tag_t old_tag;

    // Reference model state.
    phys_tag_t   ref_map [`NUM_LOGICAL];
    phys_tag_t   ref_ring [`FREE_DEPTH];
    int          ref_head;
    int          ref_tail;
    int          ref_count;
    phys_tag_t   page_map [`NUM_PAGES][`NUM_LOGICAL];
    int          page_head [`NUM_PAGES];
    int          page_pool [`NUM_PAGES];
    phys_tag_t   pool [$];                          // Displaced tags, free to commit.

    row_t        rows [$];
    string       test_names [6];
    int          cur_test;
    int unsigned lcg_state = 32'h17a7;
    int          cycles = 0;
    int          limit = 0;

    always #20 clk = ~clk;

    rename_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .opcode       (opcode),
        .src1         (src1),
        .src2         (src2),
        .dst          (dst),
        .save         (save),
        .save_page    (save_page),
        .restore      (restore),
        .restore_page (restore_page),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .dst_tag      (dst_tag),
        .old_tag      (old_tag)
    );

    tb_checker chk_i (
        .clk       (clk),
        .reset     (reset),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .dst_tag   (dst_tag),
        .old_tag   (old_tag)
    );

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Run timed out after %0d cycles before the table was done", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ***********************************************************************
    // Helpers
    // ***********************************************************************
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic op_class_e classify(input opcode_e op);
        case (op)
            op_jalr, op_load, op_imm: return src1_only;
            op_lui, op_auipc, op_jal: return no_src;
            op_branch, op_store:      return no_dst_two_src;
            default:                  return two_src;
        endcase
    endfunction

    function automatic int run_limit();
        int n;
        n = 10 + 100;
        foreach (rows[i]) begin
            if (rows[i].rs) begin
                n += 40;
            end else if (rows[i].rep == 0) begin
                n += 2 * `FREE_DEPTH;
            end else begin
                n += 3 * int'(rows[i].rep);
            end
        end
        return n;
    endfunction

    task automatic add_row(input int test, input opcode_e op, input int s1, input int s2,
                           input int d, input int sv, input int sp, input int rs,
                           input int rp, input int cm, input int rep);
        row_t r;
        r.test = 4'(test);
        r.op   = op;
        r.s1   = log_reg_t'(s1);
        r.s2   = log_reg_t'(s2);
        r.d    = log_reg_t'(d);
        r.sv   = 1'(sv);
        r.sp   = page_t'(sp);
        r.rs   = 1'(rs);
        r.rp   = page_t'(rp);
        r.cm   = 1'(cm);
        r.rep  = 8'(rep);
        rows.push_back(r);
    endtask

    task automatic clear_inputs();
        in_valid     = 1'b0;
        save         = 1'b0;
        restore      = 1'b0;
        commit_valid = 1'b0;
    endtask

    task automatic save_model(input int pg);
        for (int i = 0; i < `NUM_LOGICAL; i++) begin
            page_map[pg][i] = ref_map[i];
        end
        page_head[pg] = ref_head;
        page_pool[pg] = pool.size();
    endtask

    task automatic predict_rename(input row_t r);
        op_class_e cls;
        phys_tag_t e1;
        phys_tag_t e2;
        phys_tag_t ed;
        phys_tag_t eo;
        cls = classify(r.op);
        e1 = (cls != no_src) ? ref_map[r.s1] : `TAG_NO_SRC;
        e2 = (cls == two_src || cls == no_dst_two_src) ? ref_map[r.s2] : `TAG_NO_SRC;
        ed = `TAG_NO_DST;
        eo = `TAG_NO_DST;
        if (cls != no_dst_two_src) begin
            ed = ref_ring[ref_head];
            eo = ref_map[r.d];
            ref_map[r.d] = ed;
            ref_head = (ref_head + 1) % `FREE_DEPTH;
            ref_count--;
            pool.push_back(eo);
        end
        chk_i.expect_out(e1, e2, ed, eo);
    endtask

    // ***********************************************************************
    // Row drivers
    // ***********************************************************************
    task automatic apply_instr(input row_t r);
        logic exp_ready;
        exp_ready = !(ref_count == 0 && classify(r.op) != no_dst_two_src);
        @(negedge clk);
        clear_inputs();
        in_valid  = 1'b1;
        opcode    = r.op;
        src1      = r.s1;
        src2      = r.s2;
        dst       = r.d;
        save      = r.sv;
        save_page = r.sp;
        if (!exp_ready) begin
            @(posedge clk);
            chk_i.check_ready(1'b0, "in_ready with an empty free list");
            @(posedge clk);
            chk_i.check_ready(1'b0, "in_ready with an empty free list");
        end else begin
            if (r.sv) begin
                save_model(r.sp);                   // Checkpoint holds the state before.
            end
            @(posedge clk);
            chk_i.check_ready(1'b1, "in_ready for a renamable instruction");
            while (!in_ready) begin
                @(posedge clk);
            end
            predict_rename(r);
        end
    endtask

    task automatic apply_restore(input row_t r);
        int low;
        low = 0;
        @(negedge clk);
        clear_inputs();
        opcode       = op_branch;
        restore      = 1'b1;
        restore_page = r.rp;                        // Held until in_ready returns.
        @(posedge clk);
        chk_i.check_ready(1'b0, "in_ready in the restore request cycle");
        ref_count += (ref_head - page_head[r.rp] + `FREE_DEPTH) % `FREE_DEPTH;
        ref_head = page_head[r.rp];
        for (int i = 0; i < `NUM_LOGICAL; i++) begin
            ref_map[i] = page_map[r.rp][i];
        end
        while (pool.size() > page_pool[r.rp]) begin
            void'(pool.pop_back());
        end
        @(negedge clk);
        restore = 1'b0;
        @(posedge clk);
        while (!in_ready) begin
            low++;
            @(posedge clk);
        end
        chk_i.check_count("restore stall cycles", low, `NUM_LOGICAL);
    endtask

    task automatic apply_commit();
        int idx;
        @(negedge clk);
        clear_inputs();
        if (pool.size() == 0) begin
            chk_i.flag_error("no displaced tag is left to commit");
        end else begin
            idx = lcg_next() % pool.size();
            commit_valid = 1'b1;
            commit_tag   = pool[idx];
            pool.delete(idx);
            @(posedge clk);
            ref_ring[ref_tail] = commit_tag;
            ref_tail = (ref_tail + 1) % `FREE_DEPTH;
            ref_count++;
        end
    endtask

    task automatic finish_test(input int t);
        @(negedge clk);
        clear_inputs();
        @(negedge clk);
        chk_i.end_test(t, test_names[t]);
    endtask

    // ***********************************************************************
    // Stimulus table and main sequence
    // ***********************************************************************
    initial begin
        reset        = 1'b1;
        clear_inputs();
        opcode       = op_reg;
        src1         = '0;
        src2         = '0;
        dst          = '0;
        save_page    = '0;
        restore_page = '0;
        commit_tag   = '0;
        for (int i = 0; i < `NUM_LOGICAL; i++) begin
            ref_map[i] = phys_tag_t'(i);
        end
        for (int i = 0; i < `FREE_DEPTH; i++) begin
            ref_ring[i] = phys_tag_t'(`NUM_LOGICAL + i);
        end
        ref_head  = 0;
        ref_tail  = 0;
        ref_count = `FREE_DEPTH;
        for (int p = 0; p < `NUM_PAGES; p++) begin
            save_model(p);
        end
        test_names[1] = "source reads after reset";
        test_names[2] = "allocation order";
        test_names[3] = "no destination";
        test_names[4] = "checkpoint restore";
        test_names[5] = "empty free list";

        //      test op         s1  s2   d  sv sp rs rp cm rep
        add_row(1, op_branch,   3,  7,  0, 0, 0, 0, 0, 0, 1);
        add_row(1, op_reg,      1,  2,  5, 0, 0, 0, 0, 0, 1);
        add_row(1, op_lui,      9, 10,  6, 0, 0, 0, 0, 0, 1);
        add_row(1, op_auipc,    4,  4,  7, 0, 0, 0, 0, 0, 1);
        add_row(1, op_jal,      8,  8,  1, 0, 0, 0, 0, 0, 1);
        add_row(1, op_jalr,     4,  8,  2, 0, 0, 0, 0, 0, 1);
        add_row(1, op_load,    11, 12, 12, 0, 0, 0, 0, 0, 1);
        add_row(1, op_imm,     13, 15, 14, 0, 0, 0, 0, 0, 1);
        add_row(2, op_reg,      5,  6,  5, 0, 0, 0, 0, 0, 1);
        add_row(2, op_reg,      5,  5, 20, 0, 0, 0, 0, 0, 1);
        add_row(2, op_imm,     20,  0, 20, 0, 0, 0, 0, 0, 1);
        add_row(2, op_reg,     20,  1, 21, 0, 0, 0, 0, 0, 3);
        add_row(3, op_branch,   5, 20,  0, 0, 0, 0, 0, 0, 1);
        add_row(3, op_store,   21,  2,  0, 0, 0, 0, 0, 0, 1);
        add_row(3, op_reg,     21, 20, 22, 0, 0, 0, 0, 0, 1);
        add_row(4, op_reg,      1,  2,  1, 1, 2, 0, 0, 0, 1);
        add_row(4, op_reg,      1,  5,  5, 0, 0, 0, 0, 0, 1);
        add_row(4, op_imm,      5,  0, 20, 0, 0, 0, 0, 0, 1);
        add_row(4, op_reg,     20, 21, 21, 0, 0, 0, 0, 0, 2);
        add_row(4, op_reg,      3,  3,  3, 1, 5, 0, 0, 0, 1);
        add_row(4, op_branch,   0,  0,  0, 0, 0, 1, 2, 0, 1);
        add_row(4, op_branch,   1,  5,  0, 0, 0, 0, 0, 0, 1);
        add_row(4, op_branch,  20, 21,  0, 0, 0, 0, 0, 0, 1);
        add_row(4, op_reg,      3,  1,  3, 0, 0, 0, 0, 0, 1);
        add_row(5, op_reg,      1,  2,  9, 0, 0, 0, 0, 0, 0);
        add_row(5, op_reg,      1,  2,  9, 0, 0, 0, 0, 0, 1);
        add_row(5, op_branch,   9,  9,  0, 0, 0, 0, 0, 0, 1);
        add_row(5, op_branch,   0,  0,  0, 0, 0, 0, 0, 1, 3);
        add_row(5, op_imm,      9,  0, 10, 0, 0, 0, 0, 0, 4);
        limit = run_limit();

        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        chk_i.check_idle();

        cur_test = rows[0].test;
        foreach (rows[i]) begin
            if (rows[i].test != cur_test) begin
                finish_test(cur_test);
                cur_test = rows[i].test;
            end
            if (rows[i].rs) begin
                apply_restore(rows[i]);
            end else if (rows[i].cm) begin
                repeat (rows[i].rep) apply_commit();
            end else if (rows[i].rep == 0) begin
                while (ref_count > 0) begin
                    apply_instr(rows[i]);
                end
            end else begin
                repeat (rows[i].rep) apply_instr(rows[i]);
            end
        end
        finish_test(cur_test);

        chk_i.report_counts();
        if (chk_i.errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
rename_pkg.sv
map_table.sv
checkpoint_store.sv
free_list.sv
restore_counter.sv
rename_ctrl.sv
rename_top.sv
tb_checker.sv
tb_rename.sv
